// ==== bb_regmap_pkg.sv ====
// ----------------------------------------------------------------------
// GPS baseband register map
// bus widths, word addresses and the decoded register select
// ----------------------------------------------------------------------
`default_nettype none

package bb_regmap_pkg;

   localparam int bb_data_w = 32;
   localparam int bb_addr_w = 32;
   localparam int bb_sel_w  = bb_data_w / 8;

   // word address field of wb_adr_i
   localparam int bb_addr_lsb = 2;
   localparam int bb_addr_msb = 9;
   localparam int bb_word_w   = bb_addr_msb - bb_addr_lsb + 1;

   typedef logic [bb_word_w-1:0] bb_word_addr_t;
   typedef logic [bb_data_w-1:0] bb_data_t;

   localparam int bb_mem_depth = 8;   // scratch words
   localparam int bb_mem_idx_w = $clog2(bb_mem_depth);

   typedef logic [bb_mem_idx_w-1:0] bb_mem_idx_t;

   // one word each, scratch ranges span bb_mem_depth words
   localparam bb_word_addr_t bb_adr_mem_wr     = 8'hC0;
   localparam bb_word_addr_t bb_adr_mem_rd     = 8'hD0;
   localparam bb_word_addr_t bb_adr_status     = 8'hE0;
   localparam bb_word_addr_t bb_adr_tic_cnt    = 8'hE2;
   localparam bb_word_addr_t bb_adr_accum_cnt  = 8'hE3;
   localparam bb_word_addr_t bb_adr_sw_rst     = 8'hF0;
   localparam bb_word_addr_t bb_adr_prog_tic   = 8'hF1;
   localparam bb_word_addr_t bb_adr_prog_accum = 8'hF2;

   typedef enum logic [2:0] {
      reg_none, reg_mem, reg_status, reg_tic_cnt,
      reg_accum_cnt, reg_sw_rst, reg_prog_tic, reg_prog_accum
   } bb_reg_e;

   typedef enum logic {bus_idle, bus_ack} bb_bus_state_e;

endpackage

`default_nettype wire

// ==== bb_timebase_pkg.sv ====
// ----------------------------------------------------------------------
// GPS baseband time base definitions
// divider width, status bit positions and divider defaults
// ----------------------------------------------------------------------
`default_nettype none

package bb_timebase_pkg;

   localparam int bb_cnt_w = 24;

   typedef logic [bb_cnt_w-1:0] bb_cnt_t;

   // status register layout
   localparam int bb_stat_w     = 2;
   localparam int bb_stat_tic   = 0;
   localparam int bb_stat_accum = 1;

   typedef logic [bb_stat_w-1:0] bb_stat_t;

   // divider values after hw reset
   localparam bb_cnt_t bb_tic_reset_val   = 24'h00FFFF;
   localparam bb_cnt_t bb_accum_reset_val = 24'h00FFFF;

endpackage

`default_nettype wire

// ==== bb_reg_if.sv ====
// ----------------------------------------------------------------------
// decoded register access from the bus slave to the register block
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface bb_reg_if;

   logic                       acc_valid;   // one cycle per transfer
   logic                       write;
   bb_regmap_pkg::bb_reg_e     sel;
   bb_regmap_pkg::bb_mem_idx_t mem_idx;
   bb_regmap_pkg::bb_data_t    wdata;
   bb_regmap_pkg::bb_data_t    rdata;       // combinational from sel

   modport bus (
      output acc_valid, write, sel, mem_idx, wdata,
      input  rdata
   );

   modport regs (
      input  acc_valid, write, sel, mem_idx, wdata,
      output rdata
   );

endinterface

`default_nettype wire

// ==== bb_bus_slave.sv ====
// ----------------------------------------------------------------------
// GPS baseband Wishbone slave
// paces each transfer, decodes the word address and returns ack
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bb_bus_slave (
   input  logic                                 clk,
   input  logic                                 hw_rstn,
   input  logic [bb_regmap_pkg::bb_addr_w-1:0]  wb_adr_i,
   input  logic                                 wb_cyc_i,
   input  logic                                 wb_stb_i,
   input  logic                                 wb_we_i,
   input  bb_regmap_pkg::bb_data_t              wb_dat_i,
   output logic                                 wb_ack_o,
   output bb_regmap_pkg::bb_data_t              wb_dat_o,
   bb_reg_if.bus                                reg_bus
);

   bb_regmap_pkg::bb_bus_state_e state;
   bb_regmap_pkg::bb_word_addr_t word_adr;
   bb_regmap_pkg::bb_reg_e       sel_dec;
   logic [bb_regmap_pkg::bb_word_w-bb_regmap_pkg::bb_mem_idx_w-1:0] page;
   logic                         strobe;

   assign strobe   = wb_cyc_i & wb_stb_i;
   assign word_adr = wb_adr_i[bb_regmap_pkg::bb_addr_msb:bb_regmap_pkg::bb_addr_lsb];
   assign page     = word_adr[bb_regmap_pkg::bb_word_w-1:bb_regmap_pkg::bb_mem_idx_w];

   // address decode, both scratch pages map onto the same memory
   always_comb begin
      if (page == bb_regmap_pkg::bb_adr_mem_wr[bb_regmap_pkg::bb_word_w-1:
                                               bb_regmap_pkg::bb_mem_idx_w] ||
          page == bb_regmap_pkg::bb_adr_mem_rd[bb_regmap_pkg::bb_word_w-1:
                                               bb_regmap_pkg::bb_mem_idx_w]) begin
         sel_dec = bb_regmap_pkg::reg_mem;
      end else begin
         case (word_adr)
            bb_regmap_pkg::bb_adr_status:     sel_dec = bb_regmap_pkg::reg_status;
            bb_regmap_pkg::bb_adr_tic_cnt:    sel_dec = bb_regmap_pkg::reg_tic_cnt;
            bb_regmap_pkg::bb_adr_accum_cnt:  sel_dec = bb_regmap_pkg::reg_accum_cnt;
            bb_regmap_pkg::bb_adr_sw_rst:     sel_dec = bb_regmap_pkg::reg_sw_rst;
            bb_regmap_pkg::bb_adr_prog_tic:   sel_dec = bb_regmap_pkg::reg_prog_tic;
            bb_regmap_pkg::bb_adr_prog_accum: sel_dec = bb_regmap_pkg::reg_prog_accum;
            default:                          sel_dec = bb_regmap_pkg::reg_none;
         endcase
      end
   end

   // edge 1 issues acc_valid, edge 2 gives ack
   always_ff @(posedge clk) begin
      if (!hw_rstn) begin
         state             <= bb_regmap_pkg::bus_idle;
         reg_bus.acc_valid <= 1'b0;
         wb_ack_o          <= 1'b0;
      end else begin
         reg_bus.acc_valid <= 1'b0;
         wb_ack_o          <= reg_bus.acc_valid;
         case (state)
            bb_regmap_pkg::bus_idle: if (strobe) begin
               state             <= bb_regmap_pkg::bus_ack;
               reg_bus.acc_valid <= 1'b1;
            end
            // hold here until the master drops stb
            bb_regmap_pkg::bus_ack: if (!reg_bus.acc_valid && !strobe) begin
               state <= bb_regmap_pkg::bus_idle;
            end
            default: state <= bb_regmap_pkg::bus_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == bb_regmap_pkg::bus_idle && strobe) begin
         reg_bus.write   <= wb_we_i;
         reg_bus.sel     <= sel_dec;
         reg_bus.mem_idx <= word_adr[bb_regmap_pkg::bb_mem_idx_w-1:0];
         reg_bus.wdata   <= wb_dat_i;
      end
      if (reg_bus.acc_valid && !reg_bus.write)
         wb_dat_o <= reg_bus.rdata;   // held until the next read
   end

endmodule

`default_nettype wire

// ==== bb_ctrl_regs.sv ====
// ----------------------------------------------------------------------
// GPS baseband control registers
// divider program values, scratch memory, reset and read strobes
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bb_ctrl_regs (
   input  logic                        clk,
   input  logic                        hw_rstn,
   bb_reg_if.regs                      reg_bus,
   input  bb_timebase_pkg::bb_stat_t   status_i,
   input  bb_timebase_pkg::bb_cnt_t    tic_count_i,
   input  bb_timebase_pkg::bb_cnt_t    accum_count_i,
   output bb_timebase_pkg::bb_cnt_t    prog_tic_o,
   output bb_timebase_pkg::bb_cnt_t    prog_accum_o,
   output logic                        soft_rst_o,
   output logic                        status_rd_o
);

   bb_regmap_pkg::bb_data_t scratch_mem [bb_regmap_pkg::bb_mem_depth];
   logic wr_en;
   logic rd_en;

   assign wr_en = reg_bus.acc_valid & reg_bus.write;
   assign rd_en = reg_bus.acc_valid & ~reg_bus.write;

   // program registers survive the software reset
   always_ff @(posedge clk) begin
      if (!hw_rstn) begin
         prog_tic_o   <= bb_timebase_pkg::bb_tic_reset_val;
         prog_accum_o <= bb_timebase_pkg::bb_accum_reset_val;
         soft_rst_o   <= 1'b0;
         status_rd_o  <= 1'b0;
      end else begin
         soft_rst_o  <= wr_en && reg_bus.sel == bb_regmap_pkg::reg_sw_rst;
         status_rd_o <= rd_en && reg_bus.sel == bb_regmap_pkg::reg_status;
         if (wr_en) begin
            case (reg_bus.sel)
               bb_regmap_pkg::reg_prog_tic:
                  prog_tic_o <= reg_bus.wdata[bb_timebase_pkg::bb_cnt_w-1:0];
               bb_regmap_pkg::reg_prog_accum:
                  prog_accum_o <= reg_bus.wdata[bb_timebase_pkg::bb_cnt_w-1:0];
               default: ;   // read-only or unmapped
            endcase
         end
      end
   end

   // bus test memory
   always_ff @(posedge clk) begin
      if (wr_en && reg_bus.sel == bb_regmap_pkg::reg_mem)
         scratch_mem[reg_bus.mem_idx] <= reg_bus.wdata;
   end

   // read mux, narrow values zero padded
   always_comb begin
      case (reg_bus.sel)
         bb_regmap_pkg::reg_mem:
            reg_bus.rdata = scratch_mem[reg_bus.mem_idx];
         bb_regmap_pkg::reg_status:
            reg_bus.rdata = bb_regmap_pkg::bb_data_t'(status_i);
         bb_regmap_pkg::reg_tic_cnt:
            reg_bus.rdata = bb_regmap_pkg::bb_data_t'(tic_count_i);
         bb_regmap_pkg::reg_accum_cnt:
            reg_bus.rdata = bb_regmap_pkg::bb_data_t'(accum_count_i);
         bb_regmap_pkg::reg_prog_tic:
            reg_bus.rdata = bb_regmap_pkg::bb_data_t'(prog_tic_o);
         bb_regmap_pkg::reg_prog_accum:
            reg_bus.rdata = bb_regmap_pkg::bb_data_t'(prog_accum_o);
         default:
            reg_bus.rdata = '0;   // sw reset and unmapped
      endcase
   end

endmodule

`default_nettype wire

// ==== bb_time_base.sv ====
// ----------------------------------------------------------------------
// GPS baseband time base
// TIC and accumulation dividers as reloading down-counters
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bb_time_base (
   input  logic                      clk,
   input  logic                      hw_rstn,
   input  logic                      soft_rst_i,
   input  bb_timebase_pkg::bb_cnt_t  prog_tic_i,
   input  bb_timebase_pkg::bb_cnt_t  prog_accum_i,
   output logic                      tic_pulse_o,
   output logic                      accum_pulse_o,
   output bb_timebase_pkg::bb_cnt_t  tic_count_o,
   output bb_timebase_pkg::bb_cnt_t  accum_count_o
);

   localparam int n_div = 2;   // 0 is TIC, 1 is accumulation

   bb_timebase_pkg::bb_cnt_t load_val [n_div];
   bb_timebase_pkg::bb_cnt_t count    [n_div];
   logic [n_div-1:0]         at_zero;

   assign load_val[0] = prog_tic_i;
   assign load_val[1] = prog_accum_i;

   for (genvar i = 0; i < n_div; i++) begin : g_div
      bb_timebase_pkg::bb_cnt_t cnt;

      // period is load value plus one
      always_ff @(posedge clk) begin
         if (!hw_rstn || soft_rst_i || cnt == '0)
            cnt <= load_val[i];
         else
            cnt <= cnt - 1'b1;
      end

      assign count[i]   = cnt;
      assign at_zero[i] = (cnt == '0);
   end

   assign tic_pulse_o   = at_zero[0];
   assign accum_pulse_o = at_zero[1];
   assign tic_count_o   = count[0];
   assign accum_count_o = count[1];

endmodule

`default_nettype wire

// ==== bb_status.sv ====
// ----------------------------------------------------------------------
// GPS baseband status
// sticky TIC and accumulation flags, accum_int cleared by status read
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bb_status (
   input  logic                       clk,
   input  logic                       hw_rstn,
   input  logic                       soft_rst_i,
   input  logic                       status_rd_i,
   input  logic                       tic_pulse_i,
   input  logic                       accum_pulse_i,
   output bb_timebase_pkg::bb_stat_t  status_o,
   output logic                       accum_int_o
);

   // clear wins over a pulse in the same cycle
   always_ff @(posedge clk) begin
      if (!hw_rstn || soft_rst_i || status_rd_i) begin
         status_o    <= '0;
         accum_int_o <= 1'b0;
      end else begin
         if (tic_pulse_i)
            status_o[bb_timebase_pkg::bb_stat_tic] <= 1'b1;
         if (accum_pulse_i) begin
            status_o[bb_timebase_pkg::bb_stat_accum] <= 1'b1;
            accum_int_o                              <= 1'b1;   // to firmware
         end
      end
   end

endmodule

`default_nettype wire

// ==== gps_bb_top.sv ====
// ----------------------------------------------------------------------
// simplified GPS baseband top level
// Wishbone register slave around the global time base
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gps_bb_top (
   input  logic                                clk,
   input  logic                                hw_rstn,
   input  logic [bb_regmap_pkg::bb_addr_w-1:0] wb_adr_i,
   input  logic [bb_regmap_pkg::bb_data_w-1:0] wb_dat_i,
   input  logic [bb_regmap_pkg::bb_sel_w-1:0]  wb_sel_i,   // full words only
   input  logic                                wb_cyc_i,
   input  logic                                wb_stb_i,
   input  logic                                wb_we_i,
   output logic [bb_regmap_pkg::bb_data_w-1:0] wb_dat_o,
   output logic                                wb_ack_o,
   output logic                                accum_int
);

   bb_timebase_pkg::bb_cnt_t  prog_tic, prog_accum;
   bb_timebase_pkg::bb_cnt_t  tic_count, accum_count;
   bb_timebase_pkg::bb_stat_t status;
   logic soft_rst, status_rd;
   logic tic_pulse, accum_pulse;

   bb_reg_if reg_bus ();

   bb_bus_slave u_bus_slave (
      .clk      (clk),
      .hw_rstn  (hw_rstn),
      .wb_adr_i (wb_adr_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_dat_i (wb_dat_i),
      .wb_ack_o (wb_ack_o),
      .wb_dat_o (wb_dat_o),
      .reg_bus  (reg_bus.bus)
   );

   bb_ctrl_regs u_ctrl_regs (
      .clk (clk), .hw_rstn (hw_rstn), .reg_bus (reg_bus.regs),
      .status_i (status), .tic_count_i (tic_count), .accum_count_i (accum_count),
      .prog_tic_o (prog_tic), .prog_accum_o (prog_accum),
      .soft_rst_o (soft_rst), .status_rd_o (status_rd)
   );

   bb_time_base u_time_base (
      .clk (clk), .hw_rstn (hw_rstn), .soft_rst_i (soft_rst),
      .prog_tic_i (prog_tic), .prog_accum_i (prog_accum),
      .tic_pulse_o (tic_pulse), .accum_pulse_o (accum_pulse),
      .tic_count_o (tic_count), .accum_count_o (accum_count)
   );

   bb_status u_status (
      .clk (clk), .hw_rstn (hw_rstn), .soft_rst_i (soft_rst), .status_rd_i (status_rd),
      .tic_pulse_i (tic_pulse), .accum_pulse_i (accum_pulse),
      .status_o (status), .accum_int_o (accum_int)
   );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// ----------------------------------------------------------------------
// testbench clock and reset for the GPS baseband
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic hw_rstn_o
);

   localparam int rst_cycles = 16;

   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;   // 20 ns period
   end

   // release just after an edge, like the other stimulus
   initial begin
      hw_rstn_o = 1'b0;
      repeat (rst_cycles) @(posedge clk_o);
      #2;
      hw_rstn_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== gps_bb_chk.sv ====
// ----------------------------------------------------------------------
// bus and interrupt protocol assertions bound into the GPS baseband top
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gps_bb_chk (
   input logic        clk,
   input logic        hw_rstn,
   input logic [31:0] wb_adr_i,
   input logic        wb_cyc_i,
   input logic        wb_stb_i,
   input logic        wb_we_i,
   input logic        wb_ack_o,
   input logic        accum_int
);

   bb_regmap_pkg::bb_word_addr_t word_adr;
   logic strobe;
   logic clear_ack;   // ack of a status read or a software reset write
   int   err_count = 0;   // failed assertions so far

   assign strobe   = wb_cyc_i & wb_stb_i;
   assign word_adr = wb_adr_i[bb_regmap_pkg::bb_addr_msb:bb_regmap_pkg::bb_addr_lsb];
   assign clear_ack = wb_ack_o &&
      ((!wb_we_i && word_adr == bb_regmap_pkg::bb_adr_status) ||
       (wb_we_i && word_adr == bb_regmap_pkg::bb_adr_sw_rst));

   ack_one_cycle: assert property (@(posedge clk) disable iff (!hw_rstn)
      wb_ack_o |=> !wb_ack_o)
      else begin
         $error("wb_ack_o stayed high for more than one cycle");
         err_count++;
      end

   ack_needs_strobe: assert property (@(posedge clk) disable iff (!hw_rstn)
      wb_ack_o |-> $past(strobe, 1) && $past(strobe, 2))
      else begin
         $error("wb_ack_o without cyc and stb in the two cycles before");
         err_count++;
      end

   // master still holds the address during the ack cycle
   int_clear: assert property (@(posedge clk) disable iff (!hw_rstn)
      $fell(accum_int) |-> $past(clear_ack))
      else begin
         $error("accum_int fell without a status read or software reset");
         err_count++;
      end

endmodule

bind gps_bb_top gps_bb_chk u_chk (
   .clk (clk), .hw_rstn (hw_rstn), .wb_adr_i (wb_adr_i),
   .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
   .wb_ack_o (wb_ack_o), .accum_int (accum_int)
);

`default_nettype wire

// ==== tb_gps_bb.sv ====
// ----------------------------------------------------------------------
// GPS baseband testbench
// table of Wishbone accesses against scratch memory, dividers and status
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_gps_bb;

   typedef enum {op_wr, op_rd, op_rd_max, op_wait_int, op_int_low} tb_op_e;

   localparam int tab_size  = 48;
   localparam int ack_limit = 20;    // cycles
   localparam int int_limit = 500;
   localparam logic [31:0] full = 32'hFFFF_FFFF;

   logic        clk;
   logic        hw_rstn;
   logic [31:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        accum_int;

   tb_op_e      tab_op    [tab_size];
   logic [7:0]  tab_adr   [tab_size];
   logic [31:0] tab_wdata [tab_size];   // cycle count for op_int_low
   logic [31:0] tab_exp   [tab_size];   // upper limit for op_rd_max
   logic [31:0] tab_mask  [tab_size];
   int          tab_len;
   int          errors;
   int          checks;
   integer      seed;

   tb_clk_gen u_clk_gen (.clk_o (clk), .hw_rstn_o (hw_rstn));

   gps_bb_top dut (
      .clk (clk), .hw_rstn (hw_rstn), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i), .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i),
      .wb_we_i (wb_we_i), .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
      .accum_int (accum_int)
   );

   task automatic add_row(input tb_op_e op, input logic [7:0] adr, input logic [31:0] wdata,
                          input logic [31:0] exp, input logic [31:0] mask);
      tab_op[tab_len]    = op;
      tab_adr[tab_len]   = adr;
      tab_wdata[tab_len] = wdata;
      tab_exp[tab_len]   = exp;
      tab_mask[tab_len]  = mask;
      tab_len++;
   endtask

   // strobe held until ack and dropped for a cycle after it
   task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      int n;
      n = 0;
      @(posedge clk);
      #2;
      wb_adr_i = {22'd0, adr, 2'b00};
      wb_dat_i = wdata;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      @(negedge clk);
      while (wb_ack_o !== 1'b1 && n < ack_limit) begin
         @(negedge clk);
         n++;
      end
      if (wb_ack_o !== 1'b1) begin
         $display("timeout at %0t: no acknowledge from the DUT for word address 0x%02h",
                  $time, adr);
         errors++;
      end
      rdata = wb_dat_o;
      @(posedge clk);
      #2;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic write_word(input logic [7:0] adr, input logic [31:0] data);
      logic [31:0] rd_ignored;
      bus_access(1'b1, adr, data, rd_ignored);
   endtask

   task automatic read_word(input logic [7:0] adr, output logic [31:0] data);
      bus_access(1'b0, adr, 32'd0, data);
   endtask

   task automatic fill_table();
      logic [31:0] word [8];
      int k;
      tab_len = 0;
      add_row(op_rd, 8'h40, 0, 0, full);   // unmapped
      for (k = 0; k < 8; k++) begin
         word[k] = $random(seed);
         add_row(op_wr, bb_regmap_pkg::bb_adr_mem_wr + 8'(k), word[k], 0, 0);
      end
      for (k = 0; k < 8; k++)
         add_row(op_rd, bb_regmap_pkg::bb_adr_mem_rd + 8'(k), 0, word[k], full);
      // count register is read only and the divider still runs from its reset value
      add_row(op_wr, bb_regmap_pkg::bb_adr_tic_cnt, 32'h00AB_CDEF, 0, 0);
      add_row(op_rd_max, bb_regmap_pkg::bb_adr_tic_cnt, 0, 32'h0000_FFFF, full);
      add_row(op_rd, bb_regmap_pkg::bb_adr_prog_tic, 0, 32'h0000_FFFF, full);
      // short periods restarted by the software reset
      add_row(op_wr, bb_regmap_pkg::bb_adr_prog_tic, 9, 0, 0);
      add_row(op_wr, bb_regmap_pkg::bb_adr_prog_accum, 49, 0, 0);
      add_row(op_wr, bb_regmap_pkg::bb_adr_sw_rst, 1, 0, 0);
      add_row(op_wait_int, 0, 0, 0, 0);
      add_row(op_rd, bb_regmap_pkg::bb_adr_status, 0, 3, full);
      add_row(op_int_low, 0, 3, 0, 0);
      for (k = 0; k < 4; k++) begin
         add_row(op_rd_max, bb_regmap_pkg::bb_adr_tic_cnt, 0, 9, full);
         add_row(op_rd_max, bb_regmap_pkg::bb_adr_accum_cnt, 0, 49, full);
      end
      add_row(op_wr, bb_regmap_pkg::bb_adr_prog_tic, 32'h000F_FFFF, 0, 0);
      add_row(op_wr, bb_regmap_pkg::bb_adr_prog_accum, 32'h000F_FFFF, 0, 0);
      add_row(op_wr, bb_regmap_pkg::bb_adr_sw_rst, 1, 0, 0);
      add_row(op_rd, bb_regmap_pkg::bb_adr_status, 0, 0, full);
      add_row(op_int_low, 0, 100, 0, 0);
   endtask

   task automatic run_row(input int i);
      logic [31:0] rdata;
      int n;
      n = 0;
      case (tab_op[i])
         op_wr: write_word(tab_adr[i], tab_wdata[i]);
         op_rd: begin
            read_word(tab_adr[i], rdata);
            checks++;
            assert ((rdata & tab_mask[i]) === (tab_exp[i] & tab_mask[i]))
            else begin
               $display("[ERROR] %0t: row %0d addr 0x%02h read 0x%08h, expected 0x%08h",
                        $time, i, tab_adr[i], rdata, tab_exp[i]);
               errors++;
            end
         end
         op_rd_max: begin
            read_word(tab_adr[i], rdata);
            checks++;
            assert ((rdata & tab_mask[i]) <= tab_exp[i])
            else begin
               $display("[ERROR] %0t: row %0d addr 0x%02h read 0x%08h, above 0x%08h",
                        $time, i, tab_adr[i], rdata, tab_exp[i]);
               errors++;
            end
         end
         op_wait_int: begin
            while (accum_int !== 1'b1 && n < int_limit) begin
               @(negedge clk);
               n++;
            end
            checks++;
            assert (accum_int === 1'b1)
            else begin
               $display("[ERROR] %0t: accum_int did not rise within %0d cycles",
                        $time, int_limit);
               errors++;
            end
         end
         op_int_low: begin
            while (n < tab_wdata[i]) begin
               @(negedge clk);
               checks++;
               assert (accum_int === 1'b0)
               else begin
                  $display("[ERROR] %0t: row %0d accum_int high", $time, i);
                  errors++;
               end
               n++;
            end
         end
         default: ;
      endcase
   endtask

   initial begin
      int n;
      int i;
      seed     = 84179;
      errors   = 0;
      checks   = 0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = 4'hF;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      n = 0;
      while (hw_rstn !== 1'b1 && n < 100) begin
         @(posedge clk);
         n++;
      end
      if (hw_rstn !== 1'b1) begin
         $display("timeout at %0t: reset was never released", $time);
         errors++;
      end
      @(negedge clk);
      checks += 2;
      assert (wb_ack_o === 1'b0)
      else begin
         $display("[ERROR] %0t: wb_ack_o not low after reset", $time);
         errors++;
      end
      assert (accum_int === 1'b0)
      else begin
         $display("[ERROR] %0t: accum_int not low after reset", $time);
         errors++;
      end
      fill_table();
      for (i = 0; i < tab_len; i++)
         run_row(i);
      errors += dut.u_chk.err_count;   // bound protocol assertions
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
bb_regmap_pkg.sv
bb_timebase_pkg.sv
bb_reg_if.sv
bb_bus_slave.sv
bb_ctrl_regs.sv
bb_time_base.sv
bb_status.sv
gps_bb_top.sv
tb_clk_gen.sv
gps_bb_chk.sv
tb_gps_bb.sv

// ==== Bender.yml ====
package:
  name: gps_bb

sources:
  - bb_regmap_pkg.sv
  - bb_timebase_pkg.sv
  - bb_reg_if.sv
  - bb_bus_slave.sv
  - bb_ctrl_regs.sv
  - bb_time_base.sv
  - bb_status.sv
  - gps_bb_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - gps_bb_chk.sv
      - tb_gps_bb.sv
